// File: verilog.f
logic/icache_pkg.sv
logic/icache_tag_array.sv
logic/icache_data_array.sv
logic/icache_ctrl.sv
logic/icache_burst_rd.sv
logic/icache_top.sv
sim/icache_mem_model.sv
sim/tb_icache.sv

// File: Makefile
TOP := tb_icache

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): verilog.f logic/*.sv sim/*.sv
	verilator --binary --timing -j 0 --top-module $(TOP) -f verilog.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: sim/tb_icache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icache
  import icache_pkg::*;
();

  localparam int    WAYS     = 2;
  localparam int    IDX_BITS = 6;
  localparam word_t PATTERN  = 32'hA5C3_0F96;  // memory word = word address ^ PATTERN
  localparam int    TIMEOUT  = 100;            // cycles per wait
  localparam int    N_RAND   = 40;

  typedef enum logic [2:0] {OP_READ, OP_READ_ANY, OP_READ_FLUSH, OP_FLUSH, OP_ARM} op_t;

  typedef struct packed {
    op_t        op;
    adr_t       adr;
    logic [1:0] bursts;  // burst increment or bound for OP_READ_ANY
    logic       err;     // ack with err
  } row_t;

  logic        clk;
  logic        rst_n;
  logic        req;
  logic        flush;
  logic        err_arm;     // held until the failing read is acked
  adr_t        adr;
  adr_t        err_adr;
  cpu_rsp_t    rsp;
  bus_req_t    bus_req;
  bus_rsp_t    bus_rsp;
  logic [31:0] bursts;
  adr_t        last_adr;
  logic        after_fill;  // request goes out with a RECOVER ack
  row_t        rows [$];

  icache_top #(.WAYS(WAYS), .IDX_BITS(IDX_BITS)) icache_top_i (
    .clk_i(clk), .rst_ni(rst_n), .req_i(req), .adr_i(adr), .flush_i(flush),
    .rsp_o(rsp), .bus_o(bus_req), .bus_i(bus_rsp)
  );

  icache_mem_model #(.PATTERN(PATTERN)) mem_i (
    .clk_i(clk), .rst_ni(rst_n), .bus_i(bus_req), .bus_o(bus_rsp),
    .err_arm_i(err_arm), .err_adr_i(err_adr), .bursts_o(bursts), .last_adr_o(last_adr)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic word_t expected_word(adr_t a);
    return {a[PLEN-1:BEAT_LSB], {BEAT_LSB{1'b0}}} ^ PATTERN;
  endfunction

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    if (act !== exp)
    begin
      $display("mismatch %s: expected %h, got %h", name, exp, act);
      $display("** FAIL **");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(string what);
    $display("timed out waiting for %s", what);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic add_row(op_t op, adr_t a, logic [1:0] n, logic e);
    rows.push_back(row_t'{op, a, n, e});
  endtask

  // -------------------------------------------------------------------------
  // one row from its falling edge to the falling edge of its ack
  // -------------------------------------------------------------------------
  task automatic run_row(row_t r);
    logic [31:0] start_bursts;
    int          lat;
    int          delta;
    start_bursts = bursts;
    lat          = 0;
    case (r.op)
      OP_FLUSH, OP_ARM:
      begin
        flush   = (r.op == OP_FLUSH);
        err_arm = err_arm | (r.op == OP_ARM);
        err_adr = r.adr;
        @(negedge clk);
        flush      = 1'b0;
        after_fill = 1'b0;
      end
      default:
      begin
        req = 1'b1;
        adr = r.adr;
        if (r.op == OP_READ_FLUSH)
        begin
          do
          begin
            @(negedge clk);
            req = 1'b0;
            lat++;
            if (lat > TIMEOUT)
              report_timeout("the bus strobe");
          end
          while (!bus_req.stb);
          check_value("bus_o.size", 32'(WORD), 32'(bus_req.size));
          check_value("bus_o.btype", 32'(WRAP4), 32'(bus_req.btype));
          flush = 1'b1;  // fill is running now
          @(negedge clk);
          flush = 1'b0;
          lat   = 0;
        end
        do
        begin
          @(negedge clk);
          req = 1'b0;
          lat++;
          if (lat > TIMEOUT)
            report_timeout("the cpu ack");
        end
        while (!rsp.ack);
        delta = int'(bursts - start_bursts);
        if (r.op == OP_READ_ANY)
          check_value("burst count bound", 32'd1, 32'(delta <= int'(r.bursts)));
        else
          check_value("burst count", 32'(r.bursts), 32'(delta));
        if (delta == 1)
          check_value("bus_o.adr", r.adr, last_adr);  // critical word first
        check_value("rsp_o.err", 32'(r.err), 32'(rsp.err));
        if (!r.err)
          check_value("rsp_o.q", expected_word(r.adr), rsp.q);
        if (r.op == OP_READ && r.bursts == 2'd0)
          check_value("ack latency", after_fill ? 32'd2 : 32'd1, 32'(lat));
        if (r.err)
          err_arm = 1'b0;
        after_fill = (delta == 1);
      end
    endcase
  endtask

  task automatic build_table();
    adr_t a;
    add_row(OP_READ, 32'h0000_1000, 2'd1, 1'b0);  // cold miss
    add_row(OP_READ, 32'h0000_1004, 2'd0, 1'b0);
    add_row(OP_READ, 32'h0000_1008, 2'd0, 1'b0);
    add_row(OP_READ, 32'h0000_100C, 2'd0, 1'b0);
    add_row(OP_READ, 32'h0000_2028, 2'd1, 1'b0);  // wrapping fill from the third word
    add_row(OP_READ, 32'h0000_2020, 2'd0, 1'b0);
    add_row(OP_READ, 32'h0000_2024, 2'd0, 1'b0);
    add_row(OP_READ, 32'h0000_2028, 2'd0, 1'b0);
    add_row(OP_READ, 32'h0000_202C, 2'd0, 1'b0);
    add_row(OP_FLUSH, 32'h0000_0000, 2'd0, 1'b0);
    add_row(OP_READ, 32'h0000_1004, 2'd1, 1'b0);
    add_row(OP_READ, 32'h0000_1000, 2'd0, 1'b0);
    add_row(OP_READ_FLUSH, 32'h0000_3010, 2'd1, 1'b0);
    add_row(OP_READ, 32'h0000_3010, 2'd1, 1'b0);  // pending flush dropped it
    add_row(OP_READ, 32'h0000_3014, 2'd0, 1'b0);
    add_row(OP_ARM, 32'h0000_4040, 2'd0, 1'b0);
    add_row(OP_READ, 32'h0000_4044, 2'd1, 1'b1);
    add_row(OP_READ, 32'h0000_4044, 2'd1, 1'b0);  // line left invalid
    add_row(OP_READ, 32'h0000_4048, 2'd0, 1'b0);
    // WAYS+2 lines on set 8
    for (int k = 0; k < N_RAND; k++)
    begin
      a = 32'h0000_5080 + 32'h400 * $urandom_range(0, WAYS + 1);
      a = a + 32'd4 * $urandom_range(0, 3);
      add_row(OP_READ_ANY, a, 2'd1, 1'b0);
    end
  endtask

  initial
  begin
    void'($urandom(96));
    rst_n      = 1'b0;
    req        = 1'b0;
    flush      = 1'b0;
    err_arm    = 1'b0;
    adr        = '0;
    err_adr    = '0;
    after_fill = 1'b0;
    build_table();
    repeat (5) @(negedge clk);
    check_value("rsp_o.ack", 32'd0, 32'(rsp.ack));
    check_value("rsp_o.err", 32'd0, 32'(rsp.err));
    check_value("bus_o.stb", 32'd0, 32'(bus_req.stb));
    rst_n = 1'b1;
    @(negedge clk);
    for (int k = 0; k < rows.size(); k++)
      run_row(rows[k]);
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/icache_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module icache_mem_model
  import icache_pkg::*;
#(
  parameter word_t PATTERN = 32'h0  // word = word address ^ PATTERN
)
(
  input  wire             clk_i,
  input  wire             rst_ni,
  input  wire  bus_req_t  bus_i,
  output bus_rsp_t        bus_o,
  input  wire             err_arm_i,  // level, err on the next burst to err_adr_i
  input  wire  adr_t      err_adr_i,
  output logic [31:0]     bursts_o,
  output adr_t            last_adr_o  // stb address of the latest burst
);

  // one wrapping line read, all outputs change on falling edges
  task automatic serve_burst();
    adr_t start;
    adr_t beat_adr;
    int   err_beat;
    start      = bus_i.adr;
    bursts_o   = bursts_o + 1;
    last_adr_o = start;
    err_beat   = BURST_LEN;  // no error
    if (err_arm_i && start[PLEN-1:BLK_OFF_BITS] == err_adr_i[PLEN-1:BLK_OFF_BITS])
      err_beat = int'($urandom_range(0, BURST_LEN - 1));
    repeat ($urandom_range(0, 3)) @(negedge clk_i);  // late stb_ack stretches stb
    bus_o.stb_ack = 1'b1;
    @(negedge clk_i);
    bus_o.stb_ack = 1'b0;
    for (int b = 0; b <= err_beat && b < BURST_LEN; b++)
    begin
      repeat ($urandom_range(0, 2)) @(negedge clk_i);  // gap before the beat
      beat_adr = start;
      beat_adr[BEAT_LSB +: WORD_OFF_BITS] = start[BEAT_LSB +: WORD_OFF_BITS]
                                          + WORD_OFF_BITS'(b);  // wraps in line
      bus_o.ack = (b != err_beat);
      bus_o.err = (b == err_beat);  // err ends the burst
      bus_o.q   = {beat_adr[PLEN-1:BEAT_LSB], {BEAT_LSB{1'b0}}} ^ PATTERN;
      @(negedge clk_i);
      bus_o.ack = 1'b0;
      bus_o.err = 1'b0;
    end
  endtask

  initial
  begin
    bus_o      = '0;
    bursts_o   = '0;
    last_adr_o = '0;
    forever
    begin
      @(negedge clk_i);  // stb is stable here
      if (rst_ni && bus_i.stb)
        serve_burst();
    end
  end

endmodule

`default_nettype wire

// File: logic/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top
  import icache_pkg::*;
#(
  parameter int WAYS     = 2,
  parameter int IDX_BITS = 6
)
(
  input  wire            clk_i,
  input  wire            rst_ni,
  input  wire            req_i,
  input  wire  adr_t     adr_i,
  input  wire            flush_i,
  output cpu_rsp_t       rsp_o,
  output bus_req_t       bus_o,
  input  wire  bus_rsp_t bus_i
);

  localparam int TAG_BITS = PLEN - IDX_BITS - BLK_OFF_BITS;

  logic [IDX_BITS-1:0]      idx;
  logic                     tag_we;
  logic                     flush_clr;
  logic [WAYS-1:0]          way_sel;
  logic [WORD_OFF_BITS-1:0] word_off;
  logic [TAG_BITS-1:0]      lkp_tag;
  logic                     fill_start;
  adr_t                     fill_adr;
  line_t                    fill_line;
  logic                     sel_fill;
  logic [WAYS-1:0]          hit;
  logic                     miss;
  fill_t                    fill;
  cpu_rsp_t                 ctrl_rsp;
  word_t                    data_q;

  icache_ctrl #(.WAYS(WAYS), .IDX_BITS(IDX_BITS)) icache_ctrl_i (
    .clk_i, .rst_ni, .req_i, .adr_i, .flush_i,
    .miss_i(miss), .fill_i(fill), .idx_o(idx), .tag_we_o(tag_we),
    .flush_clr_o(flush_clr), .way_sel_o(way_sel), .word_off_o(word_off),
    .lkp_tag_o(lkp_tag), .fill_start_o(fill_start), .fill_adr_o(fill_adr),
    .fill_line_o(fill_line), .rsp_sel_fill_o(sel_fill), .rsp_o(ctrl_rsp)
  );

  icache_tag_array #(.WAYS(WAYS), .IDX_BITS(IDX_BITS)) icache_tag_array_i (
    .clk_i, .rst_ni, .idx_i(idx), .tag_we_i(tag_we), .way_sel_i(way_sel),
    .flush_clr_i(flush_clr), .lkp_tag_i(lkp_tag), .wr_valid_i(~fill.err),
    .hit_o(hit), .miss_o(miss)
  );

  icache_data_array #(.WAYS(WAYS), .IDX_BITS(IDX_BITS)) icache_data_array_i (
    .clk_i, .idx_i(idx), .we_i(tag_we), .way_sel_i(way_sel), .line_i(fill_line),
    .hit_i(hit), .word_off_i(word_off), .fill_line_i(fill_line),
    .sel_fill_i(sel_fill), .q_o(data_q)
  );

  icache_burst_rd icache_burst_rd_i (
    .clk_i, .rst_ni, .start_i(fill_start), .adr_i(fill_adr),
    .bus_i, .bus_o, .fill_o(fill)
  );

  // ack and err from the controller, word from the data array
  assign rsp_o = '{ack: ctrl_rsp.ack, err: ctrl_rsp.err, q: data_q};

endmodule

`default_nettype wire

// File: logic/icache_burst_rd.sv
`timescale 1ns/1ps
`default_nettype none

module icache_burst_rd
  import icache_pkg::*;
(
  input  wire            clk_i,
  input  wire            rst_ni,
  input  wire            start_i,
  input  wire  adr_t     adr_i,
  input  wire  bus_rsp_t bus_i,
  output bus_req_t       bus_o,
  output fill_t          fill_o
);

  typedef enum logic [1:0] {IDLE, WAIT4BIU, BURST} state_t;

  state_t                   state_q;
  adr_t                     adr_q;   // start address, stable while stb
  logic [WORD_OFF_BITS-1:0] cnt_q;   // beats left minus one
  logic [WORD_OFF_BITS-1:0] ptr_q;   // wrapping word slot
  line_t                    line_q;
  logic                     done_q;
  logic                     err_q;
  logic                     last;

  // last beat or error ends the burst
  assign last = (state_q == BURST) & (bus_i.err | (bus_i.ack & ~|cnt_q));

  // -------------------------------------------------------------------------
  // bus state machine
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= IDLE;
      cnt_q   <= '0;
      ptr_q   <= '0;
      done_q  <= 1'b0;
      err_q   <= 1'b0;
    end
    else
    begin
      done_q <= last;                                 // line complete by now
      err_q  <= (state_q == BURST) & bus_i.err;
      case (state_q)
        IDLE:
          if (start_i)
          begin
            state_q <= WAIT4BIU;
            cnt_q   <= WORD_OFF_BITS'(BURST_LEN - 1);
            ptr_q   <= adr_i[BEAT_LSB +: WORD_OFF_BITS];  // critical word first
          end
        WAIT4BIU:
          if (bus_i.stb_ack)
            state_q <= BURST;
        BURST:
          if (last)
            state_q <= IDLE;
          else if (bus_i.ack)
          begin
            cnt_q <= cnt_q - 1'b1;
            ptr_q <= ptr_q + 1'b1;  // wraps inside the line
          end
        default:
          state_q <= IDLE;
      endcase
    end
  end

  // address hold and line assembly
  always_ff @(posedge clk_i)
  begin
    if (start_i && state_q == IDLE)
      adr_q <= adr_i;
    if (state_q == BURST && bus_i.ack && !bus_i.err)
      line_q[ptr_q*XLEN +: XLEN] <= bus_i.q;
  end

  assign bus_o.stb   = (state_q == WAIT4BIU);
  assign bus_o.adr   = adr_q;
  assign bus_o.size  = WORD;
  assign bus_o.btype = WRAP4;

  assign fill_o = '{done: done_q, err: err_q, line: line_q};

endmodule

`default_nettype wire

// File: logic/icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl
  import icache_pkg::*;
#(
  parameter int WAYS     = 2,
  parameter int IDX_BITS = 6
)
(
  input  wire                                    clk_i,
  input  wire                                    rst_ni,
  input  wire                                    req_i,
  input  wire  adr_t                             adr_i,
  input  wire                                    flush_i,
  input  wire                                    miss_i,
  input  wire  fill_t                            fill_i,
  output logic [IDX_BITS-1:0]                    idx_o,
  output logic                                   tag_we_o,
  output logic                                   flush_clr_o,
  output logic [WAYS-1:0]                        way_sel_o,
  output logic [WORD_OFF_BITS-1:0]               word_off_o,
  output logic [PLEN-IDX_BITS-BLK_OFF_BITS-1:0]  lkp_tag_o,
  output logic                                   fill_start_o,
  output adr_t                                   fill_adr_o,
  output line_t                                  fill_line_o,
  output logic                                   rsp_sel_fill_o,
  output cpu_rsp_t                               rsp_o
);

  typedef enum logic [1:0] {ARMED, FILL, RECOVER} state_t;

  state_t          state_q;
  adr_t            adr_q;         // held request
  logic            lkp_q;         // tag compare due this cycle
  logic            late_q;        // request taken with the RECOVER ack
  logic            flush_pend_q;  // flush seen outside ARMED
  logic            err_q;         // fill ended with bus error
  logic [19:0]     lfsr_q;        // random replacement
  logic [WAYS-1:0] way_q;         // way being refilled
  logic            armed;
  logic            recover;
  logic            start;

  assign armed   = (state_q == ARMED);
  assign recover = (state_q == RECOVER);
  assign start   = armed & lkp_q & miss_i;

  // -------------------------------------------------------------------------
  // request and victim way
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_i)
  begin
    if (req_i)
      adr_q <= adr_i;
    if (start)
      way_q <= WAYS'(1) << (lfsr_q % WAYS);  // picked on the miss cycle
  end

  // -------------------------------------------------------------------------
  // state machine
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q      <= ARMED;
      lkp_q        <= 1'b0;
      late_q       <= 1'b0;
      flush_pend_q <= 1'b0;
      err_q        <= 1'b0;
      lfsr_q       <= '0;
    end
    else
    begin
      lkp_q        <= armed & (req_i | late_q);
      late_q       <= recover & req_i;              // looked up in the next ARMED
      flush_pend_q <= ~armed & (flush_i | flush_pend_q);
      if (state_q != FILL)
        lfsr_q <= {lfsr_q[18:0], lfsr_q[19] ~^ lfsr_q[16]};
      case (state_q)
        ARMED:
          if (start)
            state_q <= FILL;
        FILL:
          if (fill_i.done)
          begin
            state_q <= RECOVER;
            err_q   <= fill_i.err;
          end
        default:
          state_q <= ARMED;  // RECOVER lasts one cycle
      endcase
    end
  end

  // new address while ARMED, held one during fill and recovery
  assign idx_o = (armed && !late_q) ? adr_i[BLK_OFF_BITS +: IDX_BITS]
                                    : adr_q[BLK_OFF_BITS +: IDX_BITS];

  assign tag_we_o       = (state_q == FILL) & fill_i.done;  // tag, line and valid
  assign flush_clr_o    = armed & (flush_i | flush_pend_q);
  assign way_sel_o      = way_q;
  assign word_off_o     = adr_q[BEAT_LSB +: WORD_OFF_BITS];
  assign lkp_tag_o      = adr_q[PLEN-1:IDX_BITS+BLK_OFF_BITS];
  assign fill_start_o   = start;
  assign fill_adr_o     = {adr_q[PLEN-1:BEAT_LSB], {BEAT_LSB{1'b0}}};  // word aligned
  assign fill_line_o    = fill_i.line;
  assign rsp_sel_fill_o = recover;

  assign rsp_o.ack = (armed & lkp_q & ~miss_i) | recover;
  assign rsp_o.err = recover & err_q;
  assign rsp_o.q   = '0;  // word comes from the data array

endmodule

`default_nettype wire

// File: logic/icache_data_array.sv
`timescale 1ns/1ps
`default_nettype none

module icache_data_array
  import icache_pkg::*;
#(
  parameter int WAYS     = 2,
  parameter int IDX_BITS = 6
)
(
  input  wire                      clk_i,
  input  wire  [IDX_BITS-1:0]      idx_i,
  input  wire                      we_i,
  input  wire  [WAYS-1:0]          way_sel_i,
  input  wire  line_t              line_i,
  input  wire  [WAYS-1:0]          hit_i,
  input  wire  [WORD_OFF_BITS-1:0] word_off_i,
  input  wire  line_t              fill_line_i,
  input  wire                      sel_fill_i,
  output word_t                    q_o
);

  localparam int SETS = 2 ** IDX_BITS;

  line_t line_q [WAYS];  // registered read per way
  line_t way_line;       // hit way after and/or mux
  line_t src_line;

  // -------------------------------------------------------------------------
  // line memories
  // -------------------------------------------------------------------------
  for (genvar w = 0; w < WAYS; w++)
  begin : gen_way
    line_t line_mem [SETS];

    always_ff @(posedge clk_i)
    begin
      if (we_i && way_sel_i[w])
        line_mem[idx_i] <= line_i;  // refill of the chosen way
      line_q[w] <= line_mem[idx_i];
    end
  end

  // and/or mux, hit vector is one-hot or zero
  always_comb
  begin
    way_line = '0;
    for (int w = 0; w < WAYS; w++)
      way_line = way_line | (line_q[w] & {BLK_BITS{hit_i[w]}});
  end

  assign src_line = sel_fill_i ? fill_line_i : way_line;  // fill word in RECOVER
  assign q_o      = src_line[word_off_i*XLEN +: XLEN];

endmodule

`default_nettype wire

// File: logic/icache_tag_array.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tag_array
  import icache_pkg::*;
#(
  parameter int WAYS     = 2,
  parameter int IDX_BITS = 6
)
(
  input  wire                                    clk_i,
  input  wire                                    rst_ni,
  input  wire  [IDX_BITS-1:0]                    idx_i,
  input  wire                                    tag_we_i,
  input  wire  [WAYS-1:0]                        way_sel_i,
  input  wire                                    flush_clr_i,
  input  wire  [PLEN-IDX_BITS-BLK_OFF_BITS-1:0]  lkp_tag_i,
  input  wire                                    wr_valid_i,
  output logic [WAYS-1:0]                        hit_o,
  output logic                                   miss_o
);

  localparam int TAG_BITS = PLEN - IDX_BITS - BLK_OFF_BITS;
  localparam int SETS     = 2 ** IDX_BITS;

  logic [IDX_BITS-1:0] idx_q;  // index of the lookup being compared

  always_ff @(posedge clk_i)
    idx_q <= idx_i;

  // -------------------------------------------------------------------------
  // one tag memory and one valid vector per way
  // -------------------------------------------------------------------------
  for (genvar w = 0; w < WAYS; w++)
  begin : gen_way
    logic [TAG_BITS-1:0] tag_mem [SETS];
    logic [TAG_BITS-1:0] tag_q;    // registered read
    logic [SETS-1:0]     valid_q;  // flops, cleared as a whole
    logic                wr;

    assign wr = tag_we_i & way_sel_i[w];

    always_ff @(posedge clk_i)
    begin
      if (wr)
        tag_mem[idx_i] <= lkp_tag_i;  // tag of the held request
      tag_q <= tag_mem[idx_i];
    end

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
      if (!rst_ni)
        valid_q <= '0;
      else if (flush_clr_i)
        valid_q <= '0;                // flush drops every set at once
      else if (wr)
        valid_q[idx_i] <= wr_valid_i; // stays low after a bus error
    end

    // compare one cycle after the index
    assign hit_o[w] = valid_q[idx_q] & (tag_q == lkp_tag_i);
  end

  assign miss_o = ~|hit_o;

endmodule

`default_nettype wire

// File: logic/icache_pkg.sv
`default_nettype none

package icache_pkg;

  // -------------------------------------------------------------------------
  // widths
  // -------------------------------------------------------------------------
  localparam int XLEN          = 32;                 // bus and instruction word
  localparam int PLEN          = 32;                 // physical address
  localparam int BURST_LEN     = 4;                  // beats per line
  localparam int BLK_BITS      = BURST_LEN * XLEN;   // one cache line
  localparam int BLK_OFF_BITS  = $clog2(BLK_BITS / 8);
  localparam int WORD_OFF_BITS = $clog2(BURST_LEN);  // word within line
  localparam int BEAT_LSB      = $clog2(XLEN / 8);   // byte within word

  typedef logic [PLEN-1:0]     adr_t;
  typedef logic [XLEN-1:0]     word_t;
  typedef logic [BLK_BITS-1:0] line_t;

  // -------------------------------------------------------------------------
  // bus encodings
  // -------------------------------------------------------------------------
  typedef enum logic [2:0] {
    BYTE  = 3'b000,
    HWORD = 3'b001,
    WORD  = 3'b010,
    DWORD = 3'b011
  } biu_size_t;

  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    WRAP4  = 3'b010,
    WRAP8  = 3'b100,
    WRAP16 = 3'b110
  } biu_type_t;

  // -------------------------------------------------------------------------
  // cpu and bus side bundles
  // -------------------------------------------------------------------------
  typedef struct packed {
    logic  ack;
    logic  err;   // fill failed
    word_t q;
  } cpu_rsp_t;

  typedef struct packed {
    logic      stb;   // held until stb_ack
    adr_t      adr;
    biu_size_t size;
    biu_type_t btype;
  } bus_req_t;

  typedef struct packed {
    logic  stb_ack;
    logic  ack;       // one per beat
    logic  err;
    word_t q;
  } bus_rsp_t;

  // burst reader back to controller
  typedef struct packed {
    logic  done;  // single cycle
    logic  err;
    line_t line;
  } fill_t;

endpackage

`default_nettype wire
